// File: logic/wave_buffer_pkg.sv
// Sizes, bus address map and register bit positions for the wave capture buffer
`default_nettype none

package wave_buffer_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sample and beat geometry
  //////////////////////////////////////////////////////////////////////

  // One wave sample
  localparam int sample_w         = 12;
  // Channels carried in each stream beat
  localparam int num_channels     = 4;
  // Two samples per channel
  localparam int samples_per_beat = 2 * num_channels;
  localparam int sample_idx_w     = $clog2(samples_per_beat);
  // Stream data width, 96 bits
  localparam int beat_w           = samples_per_beat * sample_w;

  //////////////////////////////////////////////////////////////////////
  // Memory and bus sizes
  //////////////////////////////////////////////////////////////////////

  localparam int bus_w      = 16;
  localparam int ram_depth  = 256;
  // Depth is a power of two so the pointer wraps on overflow
  localparam int ram_addr_w = $clog2(ram_depth);
  // Top address bit set selects the register set
  localparam int bus_addr_w = ram_addr_w + 1;

  // Register addresses
  localparam logic [bus_addr_w-1:0] reg_ctrl   = bus_addr_w'(256);
  localparam logic [bus_addr_w-1:0] reg_status = bus_addr_w'(257);
  localparam logic [bus_addr_w-1:0] reg_wptr   = bus_addr_w'(258);
  localparam logic [bus_addr_w-1:0] reg_angle  = bus_addr_w'(259);

  // Control and status bit positions
  localparam int ctrl_enable_bit  = 0;
  localparam int ctrl_clear_bit   = 1;
  localparam int stat_busy_bit    = 0;
  localparam int stat_wrapped_bit = 1;

endpackage

`default_nettype wire

// File: logic/wave_unpacker.sv
// Stream beat capture, sample serializer and wrapping write pointer
`timescale 1ns/100ps
`default_nettype none

module wave_unpacker import wave_buffer_pkg::*; (
  input  wire logic                  clk_f,
  input  wire logic                  rst_ram,
  // Stream input
  input  wire logic [beat_w-1:0]     s_tdata,
  input  wire logic                  s_tvalid,
  output logic                       s_tready,
  // Control from the bus port
  input  wire logic                  capture_en,
  input  wire logic                  clear,
  // Memory write port
  output logic                       wr_en,
  output logic [ram_addr_w-1:0]      wr_addr,
  output logic [sample_w-1:0]        wr_data,
  // Status back to the bus port
  output logic [ram_addr_w-1:0]      wptr,
  output logic                       busy,
  output logic                       wrapped
);

  // Beat held while its samples go out
  logic [beat_w-1:0]       beat_q;
  // Index of the sample being written
  logic [sample_idx_w-1:0] idx_q;
  logic                    busy_q;
  logic                    wrapped_q;
  logic [ram_addr_w-1:0]   ptr_q;
  logic                    take_beat;
  logic                    last_sample;

  // Ready only while enabled, idle and out of reset
  assign s_tready    = capture_en & ~busy_q & rst_ram;
  assign take_beat   = s_tvalid & s_tready;
  assign last_sample = (idx_q == sample_idx_w'(samples_per_beat - 1));

  // Payload register, loaded on each transfer
  always_ff @(posedge clk_f) begin
    if (take_beat) begin
      beat_q <= s_tdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sample sequencer
  //////////////////////////////////////////////////////////////////////

  // Eight write cycles follow each accepted beat
  always_ff @(posedge clk_f) begin
    if (!rst_ram) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (take_beat) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end else if (busy_q) begin
      idx_q <= idx_q + 1'b1;
      // Back to idle after the last sample
      if (last_sample) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Pointer steps once per written sample
  // Clear wins, a beat in flight carries on from address 0
  always_ff @(posedge clk_f) begin
    if (!rst_ram) begin
      ptr_q     <= '0;
      wrapped_q <= 1'b0;
    end else if (clear) begin
      ptr_q     <= '0;
      wrapped_q <= 1'b0;
    end else if (busy_q) begin
      ptr_q <= ptr_q + 1'b1;
      // Sticky once the top location has been written
      if (ptr_q == '1) begin
        wrapped_q <= 1'b1;
      end
    end
  end

  // Write port, sample 0 sits in the low bits
  assign wr_en   = busy_q;
  assign wr_addr = ptr_q;
  assign wr_data = beat_q[idx_q*sample_w +: sample_w];

  assign wptr    = ptr_q;
  assign busy    = busy_q;
  assign wrapped = wrapped_q;

endmodule

`default_nettype wire

// File: logic/sample_ram.sv
// Simple dual-port sample memory with a registered read port
`timescale 1ns/100ps
`default_nettype none

module sample_ram import wave_buffer_pkg::*; (
  input  wire logic                  clk_f,
  // Write side, driven by the unpacker
  input  wire logic                  wr_en,
  input  wire logic [ram_addr_w-1:0] wr_addr,
  input  wire logic [sample_w-1:0]   wr_data,
  // Read side, driven by the bus port
  input  wire logic [ram_addr_w-1:0] rd_addr,
  output logic      [sample_w-1:0]   rd_data
);

  // Contents come up undefined
  logic [sample_w-1:0] mem [ram_depth];

  always_ff @(posedge clk_f) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Data valid one cycle after the address
  always_ff @(posedge clk_f) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: logic/mcu_bus_port.sv
// MCU bus decoder, control and angle registers, read-data mux
`timescale 1ns/100ps
`default_nettype none

module mcu_bus_port import wave_buffer_pkg::*; (
  input  wire logic                  clk_f,
  input  wire logic                  rst_ram,
  // MCU bus, strobes active low
  input  wire logic [bus_addr_w-1:0] bus_addr,
  input  wire logic [bus_w-1:0]      bus_wdata,
  input  wire logic                  bus_rd_n,
  input  wire logic                  bus_wr_n,
  output logic      [bus_w-1:0]      bus_rdata,
  // Sample memory read port
  output logic      [ram_addr_w-1:0] rd_addr,
  input  wire logic [sample_w-1:0]   rd_data,
  // Unpacker status
  input  wire logic [ram_addr_w-1:0] wptr,
  input  wire logic                  busy,
  input  wire logic                  wrapped,
  // Unpacker control
  output logic                       capture_en,
  output logic                       clear,
  // To the rotation unit
  output logic      [bus_w-1:0]      angle
);

  logic             wr_cyc;
  logic             rd_cyc;
  logic             reg_sel;
  logic             enable_q;
  logic             clear_q;
  logic [bus_w-1:0] angle_q;
  // Read pipeline
  logic             rd_valid_q;
  logic             rd_mem_q;
  logic [bus_w-1:0] reg_rdata;
  logic [bus_w-1:0] reg_rdata_q;
  logic [bus_w-1:0] mem_word;

  // Both strobes low counts as a write
  assign wr_cyc  = ~bus_wr_n;
  assign rd_cyc  = ~bus_rd_n & bus_wr_n;
  assign reg_sel = bus_addr[bus_addr_w-1];

  // Memory address goes straight through, the RAM adds the read stage
  assign rd_addr = bus_addr[ram_addr_w-1:0];

  //////////////////////////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_f) begin
    if (!rst_ram) begin
      enable_q <= 1'b0;
      angle_q  <= '0;
    end else if (wr_cyc) begin
      if (bus_addr == reg_ctrl) begin
        enable_q <= bus_wdata[ctrl_enable_bit];
      end
      if (bus_addr == reg_angle) begin
        angle_q <= bus_wdata;
      end
    end
  end

  // Clear is a one-cycle pulse, never held in the register
  always_ff @(posedge clk_f) begin
    if (!rst_ram) begin
      clear_q <= 1'b0;
    end else begin
      clear_q <= wr_cyc && (bus_addr == reg_ctrl) && bus_wdata[ctrl_clear_bit];
    end
  end

  assign capture_en = enable_q;
  assign clear      = clear_q;
  assign angle      = angle_q;

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////

  // Register set view, unmapped addresses give 0
  always_comb begin
    reg_rdata = '0;
    case (bus_addr)
      reg_ctrl: begin
        reg_rdata[ctrl_enable_bit] = enable_q;
      end
      reg_status: begin
        reg_rdata[stat_busy_bit]    = busy;
        reg_rdata[stat_wrapped_bit] = wrapped;
      end
      reg_wptr: begin
        reg_rdata = bus_w'(wptr);
      end
      reg_angle: begin
        reg_rdata = angle_q;
      end
      default: begin
        reg_rdata = '0;
      end
    endcase
  end

  // Track which source answers, refreshed each read cycle
  always_ff @(posedge clk_f) begin
    if (!rst_ram) begin
      rd_valid_q <= 1'b0;
      rd_mem_q   <= 1'b0;
    end else begin
      rd_valid_q <= rd_cyc;
      rd_mem_q   <= rd_cyc & ~reg_sel;
    end
  end

  // Register value captured alongside the memory read
  always_ff @(posedge clk_f) begin
    if (rd_cyc) begin
      reg_rdata_q <= reg_rdata;
    end
  end

  // Samples zero-extended to the bus width
  assign mem_word = {{(bus_w - sample_w){1'b0}}, rd_data};

  // Idle bus reads 0
  assign bus_rdata = !rd_valid_q ? '0 :
                     rd_mem_q    ? mem_word : reg_rdata_q;

endmodule

`default_nettype wire

// File: logic/wave_buffer.sv
// Top level of the wave capture buffer with unpacker, sample memory and bus port
`timescale 1ns/100ps
`default_nettype none

module wave_buffer import wave_buffer_pkg::*; (
  input  wire logic                  clk_f,
  input  wire logic                  rst_ram,
  // Wave stream from the datapath
  input  wire logic [beat_w-1:0]     s_tdata,
  input  wire logic                  s_tvalid,
  output logic                       s_tready,
  // MCU bus
  input  wire logic [bus_addr_w-1:0] bus_addr,
  input  wire logic [bus_w-1:0]      bus_wdata,
  input  wire logic                  bus_rd_n,
  input  wire logic                  bus_wr_n,
  output logic      [bus_w-1:0]      bus_rdata,
  // Angle for the rotation unit
  output logic      [bus_w-1:0]      angle
);

  // Memory write port
  logic                  wr_en;
  logic [ram_addr_w-1:0] wr_addr;
  logic [sample_w-1:0]   wr_data;
  // Memory read port
  logic [ram_addr_w-1:0] rd_addr;
  logic [sample_w-1:0]   rd_data;
  // Control and status between bus port and unpacker
  logic [ram_addr_w-1:0] wptr;
  logic                  busy;
  logic                  wrapped;
  logic                  capture_en;
  logic                  clear;

  // Stream side
  wave_unpacker unpacker_i (
    .clk_f      (clk_f),
    .rst_ram    (rst_ram),
    .s_tdata    (s_tdata),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .capture_en (capture_en),
    .clear      (clear),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wptr       (wptr),
    .busy       (busy),
    .wrapped    (wrapped)
  );

  // Circular sample store
  sample_ram ram_i (
    .clk_f   (clk_f),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // MCU side
  mcu_bus_port bus_i (
    .clk_f      (clk_f),
    .rst_ram    (rst_ram),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_rd_n   (bus_rd_n),
    .bus_wr_n   (bus_wr_n),
    .bus_rdata  (bus_rdata),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .wptr       (wptr),
    .busy       (busy),
    .wrapped    (wrapped),
    .capture_en (capture_en),
    .clear      (clear),
    .angle      (angle)
  );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
// Testbench clock source and power-on reset sequence
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk_f,
  output logic rst_ram
);

  // 100 ns period
  localparam int half_period  = 50;
  localparam int reset_cycles = 16;

  initial begin
    clk_f = 1'b0;
    forever #half_period clk_f = ~clk_f;
  end

  // Reset low from time 0, released on a rising edge
  initial begin
    rst_ram = 1'b0;
    repeat (reset_cycles) @(posedge clk_f);
    rst_ram <= 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/wave_buffer_checker.sv
// Reference model of sample memory and registers, with port comparison
`timescale 1ns/100ps
`default_nettype none

module wave_buffer_checker import wave_buffer_pkg::*; (
  input  wire logic                  clk_f,
  input  wire logic                  rst_ram,
  input  wire logic [beat_w-1:0]     s_tdata,
  input  wire logic                  s_tvalid,
  input  wire logic                  s_tready,
  input  wire logic [bus_addr_w-1:0] bus_addr,
  input  wire logic [bus_w-1:0]      bus_wdata,
  input  wire logic                  bus_rd_n,
  input  wire logic                  bus_wr_n,
  input  wire logic [bus_w-1:0]      bus_rdata,
  input  wire logic [bus_w-1:0]      angle,
  output int                         err_count,
  output int                         check_count
);

  // Model state
  logic [sample_w-1:0]   mem_model [ram_depth];
  logic [ram_addr_w-1:0] ptr_model;
  logic                  wrapped_model;
  logic                  enable_model;
  logic [bus_w-1:0]      angle_model;
  // Write cycles still owed by the current beat
  int                    busy_left;
  // Read seen at the last edge, data due now
  logic                  rd_pending;
  logic [bus_addr_w-1:0] rd_addr_seen;
  logic [bus_w-1:0]      rdata_exp;
  int                    errs = 0;
  int                    checks = 0;

  assign err_count   = errs;
  assign check_count = checks;

  task automatic compare_word(input string name, input logic [bus_w-1:0] exp,
                              input logic [bus_w-1:0] act);
    checks = checks + 1;
    if (act !== exp) begin
      errs = errs + 1;
      $display("MISMATCH %0s: expected 0x%h, actual 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  // Value a read of this address should return
  function automatic logic [bus_w-1:0] expected_read(input logic [bus_addr_w-1:0] addr);
    logic [bus_w-1:0] word;
    word = '0;
    if (!addr[bus_addr_w-1]) begin
      // Samples come back zero-extended
      word = bus_w'(mem_model[addr[ram_addr_w-1:0]]);
    end else if (addr == reg_ctrl) begin
      word[ctrl_enable_bit] = enable_model;
    end else if (addr == reg_status) begin
      word[stat_busy_bit]    = (busy_left > 0);
      word[stat_wrapped_bit] = wrapped_model;
    end else if (addr == reg_wptr) begin
      word = bus_w'(ptr_model);
    end else if (addr == reg_angle) begin
      word = angle_model;
    end
    return word;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare first, then update the model from this edge's inputs
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_f) begin
    if (!rst_ram) begin
      // No transfer can be offered while reset is held
      compare_word("s_tready", '0, bus_w'(s_tready));
      ptr_model     = '0;
      wrapped_model = 1'b0;
      enable_model  = 1'b0;
      angle_model   = '0;
      busy_left     = 0;
      rd_pending    = 1'b0;
    end else begin
      if (rd_pending) begin
        compare_word($sformatf("bus_rdata[0x%h]", rd_addr_seen), rdata_exp, bus_rdata);
      end else begin
        compare_word("bus_rdata idle", '0, bus_rdata);
      end
      // Ready only while enabled and idle
      compare_word("s_tready", bus_w'(enable_model && busy_left == 0), bus_w'(s_tready));
      compare_word("angle", angle_model, angle);

      // Reads sample the state before this edge
      rd_pending = !bus_rd_n && bus_wr_n;
      if (rd_pending) begin
        rd_addr_seen = bus_addr;
        rdata_exp    = expected_read(bus_addr);
      end
      if (busy_left > 0) begin
        busy_left = busy_left - 1;
      end

      // Register writes, clear never stored
      if (!bus_wr_n) begin
        if (bus_addr == reg_ctrl) begin
          enable_model = bus_wdata[ctrl_enable_bit];
          if (bus_wdata[ctrl_clear_bit]) begin
            ptr_model     = '0;
            wrapped_model = 1'b0;
          end
        end
        if (bus_addr == reg_angle) begin
          angle_model = bus_wdata;
        end
      end

      // Accepted beat, sample 0 first
      if (s_tvalid && s_tready) begin
        for (int k = 0; k < samples_per_beat; k++) begin
          mem_model[ptr_model] = s_tdata[k*sample_w +: sample_w];
          if (ptr_model == ram_addr_w'(ram_depth - 1)) begin
            wrapped_model = 1'b1;
          end
          ptr_model = ptr_model + 1'b1;
        end
        busy_left = samples_per_beat;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/wave_buffer_asserts.sv
// Concurrent assertions on the stream handshake and the bus read data
`timescale 1ns/100ps
`default_nettype none

module wave_buffer_asserts import wave_buffer_pkg::*; (
  input wire logic              clk_f,
  input wire logic              rst_ram,
  input wire logic [beat_w-1:0] s_tdata,
  input wire logic              s_tvalid,
  input wire logic              s_tready,
  input wire logic              bus_rd_n,
  input wire logic              bus_wr_n,
  input wire logic [bus_w-1:0]  bus_rdata
);

  // Read cycle only when write strobe is high
  logic read_cycle;
  int   fail_count = 0;

  assign read_cycle = !bus_rd_n && bus_wr_n;

  // Stalled source keeps its beat
  stream_hold: assert property (@(posedge clk_f) disable iff (!rst_ram)
    s_tvalid && !s_tready |=> s_tvalid && $stable(s_tdata))
    else begin
      fail_count++;
      $error("stream beat changed while stalled");
    end

  // One beat per nine cycles at most
  ready_gap: assert property (@(posedge clk_f) disable iff (!rst_ram)
    s_tvalid && s_tready |=> !s_tready [*samples_per_beat])
    else begin
      fail_count++;
      $error("s_tready rose before the beat was unpacked");
    end

  idle_rdata: assert property (@(posedge clk_f) disable iff (!rst_ram)
    !$past(read_cycle) |-> bus_rdata == '0)
    else begin
      fail_count++;
      $error("bus_rdata nonzero with no read pending");
    end

endmodule

bind wave_buffer wave_buffer_asserts asserts_i (
  .clk_f     (clk_f),
  .rst_ram   (rst_ram),
  .s_tdata   (s_tdata),
  .s_tvalid  (s_tvalid),
  .s_tready  (s_tready),
  .bus_rd_n  (bus_rd_n),
  .bus_wr_n  (bus_wr_n),
  .bus_rdata (bus_rdata)
);

`default_nettype wire

// File: dv/wave_buffer_tb.sv
// Testbench top with stream source, MCU bus cycles and test sequence
`timescale 1ns/100ps
`default_nettype none

module wave_buffer_tb import wave_buffer_pkg::*; ();

  // Cycle budget, two beat phases and about 500 bus cycles, doubled
  localparam int test_cycles = 62 * 14 + 500 * 3 + 200;
  localparam int max_cycles  = 2 * test_cycles;

  logic                  clk_f;
  logic                  rst_ram;
  logic [beat_w-1:0]     s_tdata;
  logic                  s_tvalid;
  logic                  s_tready;
  logic [bus_addr_w-1:0] bus_addr;
  logic [bus_w-1:0]      bus_wdata;
  logic                  bus_rd_n;
  logic                  bus_wr_n;
  logic [bus_w-1:0]      bus_rdata;
  logic [bus_w-1:0]      angle;
  int                    err_count;
  int                    check_count;
  int                    cycles = 0;
  int                    errs_before = 0;
  int                    tests_done = 0;
  int                    beats_sent = 0;

  tb_clock_gen clock_i (
    .clk_f   (clk_f),
    .rst_ram (rst_ram)
  );

  wave_buffer dut_i (
    .clk_f     (clk_f),
    .rst_ram   (rst_ram),
    .s_tdata   (s_tdata),
    .s_tvalid  (s_tvalid),
    .s_tready  (s_tready),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rd_n  (bus_rd_n),
    .bus_wr_n  (bus_wr_n),
    .bus_rdata (bus_rdata),
    .angle     (angle)
  );

  wave_buffer_checker checker_i (
    .clk_f       (clk_f),
    .rst_ram     (rst_ram),
    .s_tdata     (s_tdata),
    .s_tvalid    (s_tvalid),
    .s_tready    (s_tready),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_rd_n    (bus_rd_n),
    .bus_wr_n    (bus_wr_n),
    .bus_rdata   (bus_rdata),
    .angle       (angle),
    .err_count   (err_count),
    .check_count (check_count)
  );

  //////////////////////////////////////////////////////////////////////
  // Bus and stream tasks, all drive on the rising edge
  //////////////////////////////////////////////////////////////////////

  function automatic int total_errors();
    return err_count + dut_i.asserts_i.fail_count;
  endfunction

  task automatic bus_write(input logic [bus_addr_w-1:0] addr, input logic [bus_w-1:0] data);
    @(posedge clk_f);
    bus_addr  <= addr;
    bus_wdata <= data;
    bus_wr_n  <= 1'b0;
    @(posedge clk_f);
    bus_wr_n  <= 1'b1;
  endtask

  // Strobe low for two edges, checker compares after each
  task automatic bus_read(input logic [bus_addr_w-1:0] addr);
    @(posedge clk_f);
    bus_addr <= addr;
    bus_rd_n <= 1'b0;
    @(posedge clk_f);
    @(posedge clk_f);
    bus_rd_n <= 1'b1;
  endtask

  task automatic read_range(input int first, input int count);
    for (int a = first; a < first + count; a++) begin
      bus_read(bus_addr_w'(a));
    end
  endtask

  task automatic read_regs();
    bus_read(reg_ctrl);
    bus_read(reg_status);
    bus_read(reg_wptr);
    bus_read(reg_angle);
  endtask

  // Caller sits on a rising edge
  task automatic start_beat();
    s_tdata  <= {$urandom(), $urandom(), $urandom()};
    s_tvalid <= 1'b1;
  endtask

  // Ready seen at the falling edge, transfer on the next rise
  task automatic accept_beat();
    do @(negedge clk_f); while (s_tready !== 1'b1);
    @(posedge clk_f);
    s_tvalid   <= 1'b0;
    beats_sent = beats_sent + 1;
  endtask

  task automatic wait_idle();
    do @(negedge clk_f); while (s_tready !== 1'b1);
    @(posedge clk_f);
  endtask

  task automatic send_beats(input int n);
    for (int i = 0; i < n; i++) begin
      repeat ($urandom_range(5, 0)) @(posedge clk_f);
      start_beat();
      accept_beat();
    end
    wait_idle();
  endtask

  task automatic finish_test(input string name);
    repeat (2) @(posedge clk_f);
    tests_done = tests_done + 1;
    $display("Test %0d %0s: %0d errors", tests_done, name, total_errors() - errs_before);
    errs_before = total_errors();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned      seed_val;
    logic [bus_w-1:0] angle_val;
    seed_val  = $urandom(10);
    s_tdata   = '0;
    s_tvalid  = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_rd_n  = 1'b1;
    bus_wr_n  = 1'b1;
    while (rst_ram !== 1'b1) @(posedge clk_f);

    read_regs();
    finish_test("reset values");

    // Valid held with capture off
    @(posedge clk_f);
    start_beat();
    repeat (50) @(posedge clk_f);
    bus_read(reg_wptr);
    bus_write(reg_ctrl, bus_w'(1) << ctrl_enable_bit);
    accept_beat();
    wait_idle();
    read_regs();
    finish_test("capture enable gating");

    send_beats(20);
    read_range(0, beats_sent * samples_per_beat);
    bus_read(reg_wptr);
    bus_read(reg_status);
    finish_test("capture and readback");

    // 61 beats in total, well past one lap
    send_beats(40);
    bus_read(reg_status);
    bus_read(reg_wptr);
    read_range(0, ram_depth);
    finish_test("wraparound");

    bus_write(reg_ctrl, (bus_w'(1) << ctrl_enable_bit) | (bus_w'(1) << ctrl_clear_bit));
    read_regs();
    send_beats(1);
    read_range(0, samples_per_beat);
    bus_read(reg_wptr);
    finish_test("clear");

    for (int i = 0; i < 10; i++) begin
      angle_val = bus_w'($urandom());
      bus_write(reg_angle, angle_val);
      bus_read(reg_angle);
    end
    finish_test("angle register");

    $display("Done: %0d tests, %0d checks, %0d errors", tests_done, check_count, total_errors());
    if (total_errors() == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Run limit
  always @(posedge clk_f) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: wave_buffer.f
logic/wave_buffer_pkg.sv
logic/wave_unpacker.sv
logic/sample_ram.sv
logic/mcu_bus_port.sv
logic/wave_buffer.sv
dv/tb_clock_gen.sv
dv/wave_buffer_checker.sv
dv/wave_buffer_asserts.sv
dv/wave_buffer_tb.sv

// File: Bender.yml
package:
  name: wave_buffer

sources:
  # Design, package first
  - logic/wave_buffer_pkg.sv
  - logic/wave_unpacker.sv
  - logic/sample_ram.sv
  - logic/mcu_bus_port.sv
  - logic/wave_buffer.sv

  # Testbench
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/wave_buffer_checker.sv
      - dv/wave_buffer_asserts.sv
      - dv/wave_buffer_tb.sv
